// File: Bender.yml
package:
  name: core_front

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_isa_pkg.sv
      - common/core_msg_pkg.sv
      - verilog/fetch_port.sv
      - verilog/stage_reg.sv
      - decode_issue/inst_decoder.sv
      - decode_issue/regfile_pending.sv
      - decode_issue/decode_issue_unit.sv
      - execute/exec_pipe.sv
      - verilog/result_port.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/core_tb.sv

// File: common/core_msg_pkg.sv
/*
  Pipeline message structs passed between core blocks:
  fetch, issue and completion records
*/
`include "core_params.svh"

package core_msg_pkg;

  // Input side to decode
  typedef struct packed {
    logic [31:0]                inst;
    logic [31:0]                pc;
    logic [`CORE_SEQ_BITS-1:0]  seq;
  } fetch_msg;

  // Decode to execute, operands already selected
  typedef struct packed {
    rv_isa_pkg::rv_uop          uop;
    logic [31:0]                op1;
    logic [31:0]                op2;
    logic [4:0]                 waddr;
    logic                       wen;
    logic [`CORE_SEQ_BITS-1:0]  seq;
    logic [31:0]                pc;
  } issue_msg;

  // Finished instruction, also the output record
  typedef struct packed {
    logic [`CORE_SEQ_BITS-1:0]  seq;
    logic [31:0]                pc;
    logic [4:0]                 waddr;
    logic                       wen;
    logic                       illegal;
    logic [31:0]                wdata;
  } complete_msg;

endpackage

// File: common/core_params.svh
/*
  Core sizing macros: register count, sequence-number width,
  pc start value and pc step per instruction
*/
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Architectural integer registers
`define CORE_NUM_REGS 32
// Sequence number wraps at this width
`define CORE_SEQ_BITS 8
// Byte step of the pc per instruction
`define CORE_PC_STEP  4
// Pc of the first instruction after reset
`define CORE_PC_RESET 0

`endif

// File: common/rv_isa_pkg.sv
/*
  Instruction set definitions for the supported RV32 subset:
  opcode and funct constants, micro-op enum, immediate kinds
*/
package rv_isa_pkg;

  // ------------------------------------------------------------------
  // Major opcodes
  // ------------------------------------------------------------------

  // Register-register ALU ops
  localparam logic [6:0] OP_REG = 7'b0110011;
  // Register-immediate ALU ops
  localparam logic [6:0] OP_IMM = 7'b0010011;

  // ------------------------------------------------------------------
  // Funct fields
  // ------------------------------------------------------------------

  // add, sub, addi and mul all share funct3 zero
  localparam logic [2:0] F3_ADD_SUB = 3'b000;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  // M extension
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // Micro-ops seen by the execute pipe
  typedef enum logic [1:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_MUL,
    UOP_ILLEGAL
  } rv_uop;

  // Immediate forms
  typedef enum logic {
    IMM_NONE,
    IMM_I
  } rv_imm_kind;

endpackage

// File: decode_issue/decode_issue_unit.sv
/*
  Decode-issue stage: instruction register, pending-bit stall,
  operand select and issue to the execute pipe
*/
`timescale 1ns/10ps

module decode_issue_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  core_msg_pkg::fetch_msg f_msg,
  input  logic                   f_val,
  output logic                   f_rdy,
  output core_msg_pkg::issue_msg issue_msg,
  output logic                   issue_val,
  input  logic                   issue_rdy,
  input  logic                   wb_wen,
  input  logic [4:0]             wb_waddr,
  input  logic [31:0]            wb_wdata
);

  core_msg_pkg::fetch_msg ir;
  logic                   ir_val;
  rv_isa_pkg::rv_uop      dec_uop;
  logic [4:0]             dec_raddr0;
  logic [4:0]             dec_raddr1;
  logic [4:0]             dec_waddr;
  logic                   dec_wen;
  logic [31:0]            dec_imm;
  logic                   dec_op2_imm;
  logic [31:0]            rdata0;
  logic [31:0]            rdata1;
  logic                   pend0;
  logic                   pend1;
  logic                   issue_xfer;
  logic                   push;
  logic                   pop;
  logic                   waw;
  // Destinations of issued writes not yet written back, entry 0 oldest
  logic [4:0]             fl_addr [2];
  logic [1:0]             fl_val;

  // ------------------------------------------------------------------
  // Instruction register
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      ir_val <= 1'b0;
    else if (f_val && f_rdy)
      ir_val <= 1'b1;
    else if (issue_xfer)
      ir_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (f_val && f_rdy)
      ir <= f_msg;
  end

  inst_decoder inst_decoder_i (
    .inst    (ir.inst),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm     (dec_imm),
    .op2_imm (dec_op2_imm)
  );

  // Pending bit set at issue, cleared by writeback
  regfile_pending regfile_pending_i (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .set_addr (dec_waddr),
    .set_en   (push),
    .wen      (wb_wen),
    .waddr    (wb_waddr),
    .wdata    (wb_wdata)
  );

  // ------------------------------------------------------------------
  // Hazards and issue
  // ------------------------------------------------------------------

  assign push = issue_xfer && dec_wen && dec_waddr != 5'd0;
  assign pop  = wb_wen && wb_waddr != 5'd0;

  // Destination still owed by an older write
  // Otherwise that write would clear the newer pending bit early
  assign waw = dec_wen && dec_waddr != 5'd0 &&
               ((fl_val[0] && fl_addr[0] == dec_waddr) ||
                (fl_val[1] && fl_addr[1] == dec_waddr));

  always_ff @(posedge clk) begin
    if (rst)
      fl_val <= 2'b00;
    else if (push && pop)
      fl_val <= fl_val;
    else if (push)
      fl_val <= {fl_val[0], 1'b1};
    else if (pop)
      fl_val <= {1'b0, fl_val[1]};
  end

  // Writes retire in order, so a pop always takes entry 0
  always_ff @(posedge clk) begin
    if (pop) begin
      fl_addr[0] <= fl_addr[1];
      if (push && fl_val[1])
        fl_addr[1] <= dec_waddr;
      else if (push)
        fl_addr[0] <= dec_waddr;
    end else if (push) begin
      if (fl_val[0])
        fl_addr[1] <= dec_waddr;
      else
        fl_addr[0] <= dec_waddr;
    end
  end

  assign issue_val  = ir_val && !pend0 && !pend1 && !waw;
  assign issue_xfer = issue_val && issue_rdy;
  // Refill in the cycle we issue
  assign f_rdy      = !ir_val || issue_xfer;

  assign issue_msg = '{
    uop:   dec_uop,
    op1:   rdata0,
    op2:   dec_op2_imm ? dec_imm : rdata1,
    waddr: dec_waddr,
    wen:   dec_wen,
    seq:   ir.seq,
    pc:    ir.pc
  };

endmodule

// File: decode_issue/inst_decoder.sv
/*
  Combinational decoder for add, sub, mul and addi
  Includes the I-type immediate generator
*/
`timescale 1ns/10ps

module inst_decoder (
  input  logic [31:0]       inst,
  output rv_isa_pkg::rv_uop uop,
  output logic [4:0]        raddr0,
  output logic [4:0]        raddr1,
  output logic [4:0]        waddr,
  output logic              wen,
  output logic [31:0]       imm,
  output logic              op2_imm
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  rv_isa_pkg::rv_imm_kind imm_kind;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ------------------------------------------------------------------
  // Field decode
  // ------------------------------------------------------------------

  always_comb begin
    // Illegal by default, no reads, no write
    uop      = rv_isa_pkg::UOP_ILLEGAL;
    raddr0   = 5'd0;
    raddr1   = 5'd0;
    waddr    = 5'd0;
    wen      = 1'b0;
    imm_kind = rv_isa_pkg::IMM_NONE;
    op2_imm  = 1'b0;
    if (opcode == rv_isa_pkg::OP_REG && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
      // R-type, funct7 picks the op
      if (funct7 == rv_isa_pkg::F7_BASE)
        uop = rv_isa_pkg::UOP_ADD;
      else if (funct7 == rv_isa_pkg::F7_SUB)
        uop = rv_isa_pkg::UOP_SUB;
      else if (funct7 == rv_isa_pkg::F7_MULDIV)
        uop = rv_isa_pkg::UOP_MUL;
      if (uop != rv_isa_pkg::UOP_ILLEGAL) begin
        raddr0 = inst[19:15];
        raddr1 = inst[24:20];
        waddr  = inst[11:7];
        wen    = 1'b1;
      end
    end else if (opcode == rv_isa_pkg::OP_IMM && funct3 == rv_isa_pkg::F3_ADD_SUB) begin
      // addi, rs2 slot unused
      uop      = rv_isa_pkg::UOP_ADD;
      raddr0   = inst[19:15];
      waddr    = inst[11:7];
      wen      = 1'b1;
      imm_kind = rv_isa_pkg::IMM_I;
      op2_imm  = 1'b1;
    end
  end

  // Immediate, sign-extended from bit 31
  always_comb begin
    case (imm_kind)
      rv_isa_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
      default:           imm = 32'd0;
    endcase
  end

endmodule

// File: decode_issue/regfile_pending.sv
/*
  Integer register file with one pending bit per register
  Two combinational read ports, one write port, x0 fixed at zero
*/
`timescale 1ns/10ps
`include "core_params.svh"

module regfile_pending (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  output logic        pend0,
  output logic        pend1,
  input  logic [4:0]  set_addr,
  input  logic        set_en,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0]               regs [`CORE_NUM_REGS];
  logic [`CORE_NUM_REGS-1:0] pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++)
        regs[i] <= 32'd0;
      pend <= '0;
    end else begin
      if (wen && waddr != 5'd0) begin
        regs[waddr] <= wdata;
        pend[waddr] <= 1'b0;
      end
      // Later assignment, so a set beats a clear
      if (set_en && set_addr != 5'd0)
        pend[set_addr] <= 1'b1;
    end
  end

  // x0 reads zero, its pending bit is never set
  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign pend0  = pend[raddr0];
  assign pend1  = pend[raddr1];

endmodule

// File: execute/exec_pipe.sv
/*
  Two-stage execute pipe: operand stage, ALU/multiplier,
  completion record stage
*/
`timescale 1ns/10ps

module exec_pipe (
  input  logic                      clk,
  input  logic                      rst,
  input  core_msg_pkg::issue_msg    issue_msg,
  input  logic                      issue_val,
  output logic                      issue_rdy,
  output core_msg_pkg::complete_msg cpl_msg,
  output logic                      cpl_val,
  input  logic                      cpl_rdy
);

  core_msg_pkg::issue_msg    x_msg;
  logic                      x_val;
  logic                      x_rdy;
  core_msg_pkg::complete_msg x_cpl;
  logic [31:0]               result;
  logic                      illegal;

  // Stage 1 holds the operands
  stage_reg #(
    .t_msg (core_msg_pkg::issue_msg)
  ) op_stage_i (
    .clk     (clk),
    .rst     (rst),
    .in_msg  (issue_msg),
    .in_val  (issue_val),
    .in_rdy  (issue_rdy),
    .out_msg (x_msg),
    .out_val (x_val),
    .out_rdy (x_rdy)
  );

  // ------------------------------------------------------------------
  // ALU between the stages
  // ------------------------------------------------------------------

  assign illegal = (x_msg.uop == rv_isa_pkg::UOP_ILLEGAL);

  always_comb begin
    case (x_msg.uop)
      rv_isa_pkg::UOP_ADD: result = x_msg.op1 + x_msg.op2;
      rv_isa_pkg::UOP_SUB: result = x_msg.op1 - x_msg.op2;
      // Low word of the product
      rv_isa_pkg::UOP_MUL: result = x_msg.op1 * x_msg.op2;
      default:             result = 32'd0;
    endcase
  end

  assign x_cpl = '{
    seq:     x_msg.seq,
    pc:      x_msg.pc,
    waddr:   x_msg.waddr,
    wen:     x_msg.wen && !illegal,
    illegal: illegal,
    wdata:   result
  };

  // Stage 2 holds the completion record
  stage_reg #(
    .t_msg (core_msg_pkg::complete_msg)
  ) cpl_stage_i (
    .clk     (clk),
    .rst     (rst),
    .in_msg  (x_cpl),
    .in_val  (x_val),
    .in_rdy  (x_rdy),
    .out_msg (cpl_msg),
    .out_val (cpl_val),
    .out_rdy (cpl_rdy)
  );

endmodule

// File: list.f
+incdir+common
common/rv_isa_pkg.sv
common/core_msg_pkg.sv
verilog/fetch_port.sv
verilog/stage_reg.sv
decode_issue/inst_decoder.sv
decode_issue/regfile_pending.sv
decode_issue/decode_issue_unit.sv
execute/exec_pipe.sv
verilog/result_port.sv
verilog/core_top.sv
testbench/core_tb.sv

// File: testbench/core_tb.sv
/*
  Testbench for the core front end
  Directed and LFSR-driven instruction stream over the four-phase input,
  reference model and in-order checker on the completion port
*/
`timescale 1ns/10ps
`include "core_params.svh"

module core_tb;

  localparam int NUM_DIRECTED = 10;
  localparam int NUM_RANDOM   = 150;
  localparam int NUM_WORDS    = NUM_DIRECTED + NUM_RANDOM;
  localparam int WAIT_LIMIT   = 2000;

  logic                      clk;
  logic                      rst;
  logic                      inst_req;
  logic [31:0]               inst;
  logic                      inst_ack;
  logic                      res_req;
  core_msg_pkg::complete_msg res;
  logic                      res_ack;

  logic [31:0] lfsr_state;
  logic [31:0] model_regs [`CORE_NUM_REGS];
  logic [31:0] words [NUM_WORDS];
  int          send_gap [NUM_WORDS];
  int          ack_gap [NUM_WORDS];
  logic [31:0] sent_q [$];
  int          err_cnt;
  int          rcv_cnt;

  core_top core_top_i (
    .clk      (clk),
    .rst      (rst),
    .inst_req (inst_req),
    .inst     (inst),
    .inst_ack (inst_ack),
    .res_req  (res_req),
    .res      (res),
    .res_ack  (res_ack)
  );

  always #50 clk = ~clk;

  // ------------------------------------------------------------------
  // Random source
  // ------------------------------------------------------------------

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // ------------------------------------------------------------------
  // Instruction encoding
  // ------------------------------------------------------------------

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
    return {imm, rs1, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OP_IMM};
  endfunction

  // Registers x0 to x7 only, so hazards are frequent
  function automatic logic [31:0] random_word();
    logic [2:0]  cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    cls = 3'(take_bits(3));
    rd  = 5'(take_bits(3));
    rs1 = 5'(take_bits(3));
    rs2 = 5'(take_bits(3));
    imm = 12'(take_bits(12));
    case (cls)
      3'd0, 3'd1: return encode_r(rv_isa_pkg::F7_BASE, rs2, rs1, rd);
      3'd2:       return encode_r(rv_isa_pkg::F7_SUB, rs2, rs1, rd);
      3'd3, 3'd4: return encode_i(imm, rs1, rd);
      3'd5:       return encode_r(rv_isa_pkg::F7_MULDIV, rs2, rs1, rd);
      // Unknown funct7 on the register opcode
      3'd6:       return encode_r(7'b0100001, rs2, rs1, rd);
      // Shift encoding, funct3 not supported
      default:    return {imm, rs1, 3'b001, rd, rv_isa_pkg::OP_IMM};
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  // Executes one word in program order on the model register file
  function automatic core_msg_pkg::complete_msg ref_exec(input logic [31:0] w, input int idx);
    core_msg_pkg::complete_msg r;
    logic [31:0]               a;
    logic [31:0]               b;
    logic [31:0]               imm;
    logic                      reg_op;
    logic                      imm_op;
    reg_op = (w[6:0] == rv_isa_pkg::OP_REG) && (w[14:12] == 3'b000);
    imm_op = (w[6:0] == rv_isa_pkg::OP_IMM) && (w[14:12] == 3'b000);
    a      = model_regs[w[19:15]];
    b      = model_regs[w[24:20]];
    imm    = {{20{w[31]}}, w[31:20]};
    r.seq     = idx[`CORE_SEQ_BITS-1:0];
    r.pc      = 32'(`CORE_PC_RESET) + 32'(idx) * 32'(`CORE_PC_STEP);
    r.waddr   = w[11:7];
    r.wen     = 1'b1;
    r.illegal = 1'b0;
    if (reg_op && w[31:25] == 7'b0000000)
      r.wdata = a + b;
    else if (reg_op && w[31:25] == 7'b0100000)
      r.wdata = a - b;
    else if (reg_op && w[31:25] == 7'b0000001)
      r.wdata = a * b;
    else if (imm_op)
      r.wdata = a + imm;
    else begin
      r.waddr   = 5'd0;
      r.wen     = 1'b0;
      r.illegal = 1'b1;
      r.wdata   = 32'd0;
    end
    // x0 stays zero
    if (r.wen && r.waddr != 5'd0)
      model_regs[r.waddr] = r.wdata;
    return r;
  endfunction

  // ------------------------------------------------------------------
  // Checks and waits
  // ------------------------------------------------------------------

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %0t: record %0d %s is %h, expected %h", $time, idx, name, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors: %0d mismatches, %0d of %0d records received", err_cnt, rcv_cnt,
             NUM_WORDS);
    $display("Regression failed");
    $finish;
  endtask

  task automatic wait_inst_ack(input logic level);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (inst_ack !== level && cnt < WAIT_LIMIT);
    if (inst_ack !== level)
      abort_run($sformatf("Timed out waiting for inst_ack to become %0b", level));
  endtask

  task automatic wait_res_req(input logic level);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (res_req !== level && cnt < WAIT_LIMIT);
    if (res_req !== level)
      abort_run($sformatf("Timed out waiting for res_req to become %0b", level));
  endtask

  // ------------------------------------------------------------------
  // Four-phase source and sink
  // ------------------------------------------------------------------

  task automatic send_all();
    for (int i = 0; i < NUM_WORDS; i++) begin
      repeat (send_gap[i]) @(posedge clk);
      inst_req <= 1'b1;
      inst     <= words[i];
      sent_q.push_back(words[i]);
      wait_inst_ack(1'b1);
      inst_req <= 1'b0;
      wait_inst_ack(1'b0);
    end
  endtask

  // Compares each record with the oldest outstanding word
  task automatic receive_all();
    core_msg_pkg::complete_msg exp;
    logic [31:0]               w;
    for (int i = 0; i < NUM_WORDS; i++) begin
      wait_res_req(1'b1);
      if (sent_q.size() == 0) begin
        err_cnt++;
        $display("Completion record %0d arrived with no instruction outstanding", i);
      end else begin
        w   = sent_q.pop_front();
        exp = ref_exec(w, i);
        compare_field("seq", 32'(res.seq), 32'(exp.seq), i);
        compare_field("pc", res.pc, exp.pc, i);
        compare_field("waddr", 32'(res.waddr), 32'(exp.waddr), i);
        compare_field("wen", 32'(res.wen), 32'(exp.wen), i);
        compare_field("illegal", 32'(res.illegal), 32'(exp.illegal), i);
        compare_field("wdata", res.wdata, exp.wdata, i);
        // Only records matched to a sent word count
        rcv_cnt++;
      end
      // Back-pressure before the ack
      repeat (ack_gap[i]) @(posedge clk);
      res_ack <= 1'b1;
      wait_res_req(1'b0);
      res_ack <= 1'b0;
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    inst_req   = 1'b0;
    inst       = 32'd0;
    res_ack    = 1'b0;
    err_cnt    = 0;
    rcv_cnt    = 0;
    lfsr_state = 32'h6a02;
    for (int r = 0; r < `CORE_NUM_REGS; r++)
      model_regs[r] = 32'd0;

    // Dependent chain, negative immediates, x0 write, illegal word
    words[0] = encode_i(12'hffb, 5'd0, 5'd1);
    words[1] = encode_i(12'h007, 5'd0, 5'd2);
    words[2] = encode_r(rv_isa_pkg::F7_MULDIV, 5'd2, 5'd1, 5'd3);
    words[3] = encode_r(rv_isa_pkg::F7_SUB, 5'd1, 5'd3, 5'd4);
    words[4] = encode_r(rv_isa_pkg::F7_BASE, 5'd2, 5'd1, 5'd0);
    words[5] = encode_r(rv_isa_pkg::F7_BASE, 5'd2, 5'd0, 5'd5);
    words[6] = 32'hffff_ffff;
    words[7] = encode_r(rv_isa_pkg::F7_BASE, 5'd1, 5'd1, 5'd6);
    words[8] = encode_i(12'h800, 5'd7, 5'd7);
    words[9] = encode_r(rv_isa_pkg::F7_MULDIV, 5'd1, 5'd1, 5'd1);
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      send_gap[i] = 0;
      ack_gap[i]  = 0;
    end
    for (int i = NUM_DIRECTED; i < NUM_WORDS; i++) begin
      words[i]    = random_word();
      send_gap[i] = take_bits(2);
      ack_gap[i]  = take_bits(2);
      // Occasional long hold on either side
      if (take_bits(4) == 0)
        ack_gap[i] = 40;
      if (take_bits(4) == 0)
        send_gap[i] = 20;
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Quiet ports with no requests
    repeat (10) begin
      @(posedge clk);
      assert (inst_ack === 1'b0 && res_req === 1'b0) else begin
        err_cnt++;
        $display("[ERROR] %0t: inst_ack %b res_req %b while idle", $time, inst_ack, res_req);
      end
    end

    fork
      send_all();
      receive_all();
    join

    // Nothing extra after the last record
    repeat (30) begin
      @(posedge clk);
      assert (res_req === 1'b0) else begin
        err_cnt++;
        $display("[ERROR] %0t: res_req raised after the last record", $time);
      end
    end
    assert (rcv_cnt == NUM_WORDS && sent_q.size() == 0) else begin
      err_cnt++;
      $display("Record count %0d does not match %0d words sent", rcv_cnt, NUM_WORDS);
    end

    $display("Errors: %0d mismatches, %0d of %0d records received", err_cnt, rcv_cnt,
             NUM_WORDS);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: verilog/core_top.sv
/*
  Core top level: input side, decode-issue, execute, output side
*/
`timescale 1ns/10ps

module core_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_req,
  input  logic [31:0]               inst,
  output logic                      inst_ack,
  output logic                      res_req,
  output core_msg_pkg::complete_msg res,
  input  logic                      res_ack
);

  core_msg_pkg::fetch_msg    f_msg;
  logic                      f_val;
  logic                      f_rdy;
  core_msg_pkg::issue_msg    issue_msg;
  logic                      issue_val;
  logic                      issue_rdy;
  core_msg_pkg::complete_msg cpl_msg;
  logic                      cpl_val;
  logic                      cpl_rdy;
  // Writeback from the output side into the register file
  logic                      wb_wen;
  logic [4:0]                wb_waddr;
  logic [31:0]               wb_wdata;

  fetch_port fetch_port_i (
    .clk      (clk),
    .rst      (rst),
    .inst_req (inst_req),
    .inst     (inst),
    .inst_ack (inst_ack),
    .f_msg    (f_msg),
    .f_val    (f_val),
    .f_rdy    (f_rdy)
  );

  decode_issue_unit decode_issue_unit_i (
    .clk       (clk),
    .rst       (rst),
    .f_msg     (f_msg),
    .f_val     (f_val),
    .f_rdy     (f_rdy),
    .issue_msg (issue_msg),
    .issue_val (issue_val),
    .issue_rdy (issue_rdy),
    .wb_wen    (wb_wen),
    .wb_waddr  (wb_waddr),
    .wb_wdata  (wb_wdata)
  );

  exec_pipe exec_pipe_i (
    .clk       (clk),
    .rst       (rst),
    .issue_msg (issue_msg),
    .issue_val (issue_val),
    .issue_rdy (issue_rdy),
    .cpl_msg   (cpl_msg),
    .cpl_val   (cpl_val),
    .cpl_rdy   (cpl_rdy)
  );

  result_port result_port_i (
    .clk      (clk),
    .rst      (rst),
    .cpl_msg  (cpl_msg),
    .cpl_val  (cpl_val),
    .cpl_rdy  (cpl_rdy),
    .res_req  (res_req),
    .res      (res),
    .res_ack  (res_ack),
    .wb_wen   (wb_wen),
    .wb_waddr (wb_waddr),
    .wb_wdata (wb_wdata)
  );

endmodule

// File: verilog/fetch_port.sv
/*
  Four-phase instruction receiver
  Tags each word with pc and sequence number, offers it val/rdy
*/
`timescale 1ns/10ps
`include "core_params.svh"

module fetch_port (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_req,
  input  logic [31:0]            inst,
  output logic                   inst_ack,
  output core_msg_pkg::fetch_msg f_msg,
  output logic                   f_val,
  input  logic                   f_rdy
);

  logic [31:0]               pc_cnt;
  logic [`CORE_SEQ_BITS-1:0] seq_cnt;
  logic                      capture;

  // New word only once ack is down and the buffer is free
  assign capture = inst_req && !inst_ack && !f_val;

  // Handshake and buffer state
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_ack <= 1'b0;
      f_val    <= 1'b0;
      pc_cnt   <= 32'(`CORE_PC_RESET);
      seq_cnt  <= '0;
    end else begin
      if (capture) begin
        inst_ack <= 1'b1;
        f_val    <= 1'b1;
        pc_cnt   <= pc_cnt + 32'(`CORE_PC_STEP);
        seq_cnt  <= seq_cnt + 1'b1;
      end else begin
        // Source released req
        if (inst_ack && !inst_req)
          inst_ack <= 1'b0;
        // Decode took the word
        if (f_val && f_rdy)
          f_val <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (capture)
      f_msg <= '{inst: inst, pc: pc_cnt, seq: seq_cnt};
  end

endmodule

// File: verilog/result_port.sv
/*
  Four-phase sender of completion records
  Drives the register-file write when a record is captured
*/
`timescale 1ns/10ps

module result_port (
  input  logic                      clk,
  input  logic                      rst,
  input  core_msg_pkg::complete_msg cpl_msg,
  input  logic                      cpl_val,
  output logic                      cpl_rdy,
  output logic                      res_req,
  output core_msg_pkg::complete_msg res,
  input  logic                      res_ack,
  output logic                      wb_wen,
  output logic [4:0]                wb_waddr,
  output logic [31:0]               wb_wdata
);

  // Record held from capture until ack has dropped
  logic busy;
  logic capture;

  // Idle only after the full four-phase cycle
  assign cpl_rdy = !busy;
  assign capture = cpl_val && cpl_rdy;

  // ------------------------------------------------------------------
  // Register-file write
  // ------------------------------------------------------------------

  // One-cycle pulse in the capture cycle, never for illegal records
  assign wb_wen   = capture && cpl_msg.wen && !cpl_msg.illegal;
  assign wb_waddr = cpl_msg.waddr;
  assign wb_wdata = cpl_msg.wdata;

  // ------------------------------------------------------------------
  // Four-phase sender
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      res_req <= 1'b0;
    end else begin
      if (capture) begin
        busy    <= 1'b1;
        res_req <= 1'b1;
      end else if (res_req && res_ack) begin
        // Sink took the record
        res_req <= 1'b0;
      end else if (busy && !res_req && !res_ack) begin
        // Ack back down, ready for the next record
        busy <= 1'b0;
      end
    end
  end

  // Payload held while req is up
  always_ff @(posedge clk) begin
    if (capture)
      res <= cpl_msg;
  end

endmodule

// File: verilog/stage_reg.sv
/*
  Single val/rdy pipeline slot with a type-parameter payload
*/
`timescale 1ns/10ps

module stage_reg #(
  parameter type t_msg = logic
) (
  input  logic clk,
  input  logic rst,
  input  t_msg in_msg,
  input  logic in_val,
  output logic in_rdy,
  output t_msg out_msg,
  output logic out_val,
  input  logic out_rdy
);

  // Room when empty or draining this cycle
  assign in_rdy = !out_val || out_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      out_val <= 1'b0;
    else if (in_val && in_rdy)
      out_val <= 1'b1;
    else if (out_rdy)
      out_val <= 1'b0;
  end

  // Held under back-pressure
  always_ff @(posedge clk) begin
    if (in_val && in_rdy)
      out_msg <= in_msg;
  end

endmodule
